//--- vlog.f
+incdir+include
design/rf_pkg.sv
design/rf_wr_if.sv
design/rf_write_decode.sv
design/int_reg_bank.sv
design/fp_reg_bank.sv
design/rf_read_mux.sv
design/reg_file_top.sv
test/tb_reg_file.sv

//--- Makefile
# Verilator build and run of the register file testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_reg_file, search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_reg_file
	./obj_dir/Vtb_reg_file | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_reg_file.sv
// register file testbench with LFSR stimulus, a reference model and assertions on every output
`default_nettype none

`include "rf_macros.svh"

module tb_reg_file;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_limit = 8; // cycles allowed per wait loop

	logic              Clk = 1'b0;
	logic              rst_i;
	rf_pkg::reg_addr_t rs_addr_i;
	rf_pkg::reg_addr_t rt_addr_i;
	rf_pkg::reg_addr_t wr_addr_i;
	rf_pkg::word_t     wr_data_i;
	rf_pkg::dword_t    wr_data64_i;
	logic              reg_write_i;
	logic              load_byte_i;
	logic              store_byte_i;
	logic              jal_i;
	logic              float_read_i;
	logic              float_write_i;
	logic              wide_write_i;
	logic              muldiv_i;
	logic              store_fp_i;
	rf_pkg::word_t     rs_data_o;
	rf_pkg::word_t     rs_msw_o;
	rf_pkg::word_t     rt_data_o;
	rf_pkg::word_t     rt_msw_o;
	rf_pkg::word_t     hi_o;
	rf_pkg::word_t     lo_o;
	logic              fp_flag_o;

	// reference model state
	rf_pkg::word_t     m_int [`RF_NREGS];
	rf_pkg::dword_t    m_fp [`RF_NPAIRS];
	rf_pkg::dword_t    m_hilo;
	rf_pkg::word_t     exp_rs_data;
	rf_pkg::word_t     exp_rs_msw;
	rf_pkg::word_t     exp_rt_data;
	rf_pkg::word_t     exp_rt_msw;
	rf_pkg::word_t     exp_hi;
	rf_pkg::word_t     exp_lo;
	logic              exp_flag;

	logic [15:0]       lfsr_q;
	string             test_name = "reset";
	int                mismatch_count = 0;
	int                timeout_count = 0;
	int                checked_cycles = 0;

	reg_file_top DUT (
		.Clk           (Clk),
		.rst_i         (rst_i),
		.rs_addr_i     (rs_addr_i),
		.rt_addr_i     (rt_addr_i),
		.wr_addr_i     (wr_addr_i),
		.wr_data_i     (wr_data_i),
		.wr_data64_i   (wr_data64_i),
		.reg_write_i   (reg_write_i),
		.load_byte_i   (load_byte_i),
		.store_byte_i  (store_byte_i),
		.jal_i         (jal_i),
		.float_read_i  (float_read_i),
		.float_write_i (float_write_i),
		.wide_write_i  (wide_write_i),
		.muldiv_i      (muldiv_i),
		.store_fp_i    (store_fp_i),
		.rs_data_o     (rs_data_o),
		.rs_msw_o      (rs_msw_o),
		.rt_data_o     (rt_data_o),
		.rt_msw_o      (rt_msw_o),
		.hi_o          (hi_o),
		.lo_o          (lo_o),
		.fp_flag_o     (fp_flag_o)
	);

	always #5 Clk = ~Clk; // 10 ns period

	// 16-bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			v      = {v[62:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic logic rand_bit();
		logic [63:0] v;
		v = rand_bits(1);
		return v[0];
	endfunction

	function automatic rf_pkg::reg_addr_t rand_addr();
		return rf_pkg::reg_addr_t'(rand_bits(`RF_ADDR_W));
	endfunction

	function automatic rf_pkg::reg_addr_t rand_even_addr();
		return rf_pkg::reg_addr_t'(rand_bits(`RF_ADDR_W - 1) << 1);
	endfunction

	function automatic rf_pkg::word_t rand_word();
		return rf_pkg::word_t'(rand_bits(`RF_WORD_W));
	endfunction

	function automatic rf_pkg::dword_t rand_dword();
		return rand_bits(2 * `RF_WORD_W);
	endfunction

	function automatic rf_pkg::word_t msw(input rf_pkg::dword_t d);
		return d[2*`RF_WORD_W-1:`RF_WORD_W];
	endfunction

	function automatic rf_pkg::word_t lsw(input rf_pkg::dword_t d);
		return d[`RF_WORD_W-1:0];
	endfunction

	function automatic rf_pkg::word_t low_byte(input rf_pkg::word_t w);
		return rf_pkg::word_t'(w[`RF_BYTE_W-1:0]);
	endfunction

	// write priority is hi/lo, then float pair, then integer
	function automatic void model_write();
		rf_pkg::reg_addr_t dest;
		rf_pkg::word_t     value;
		if (!reg_write_i) begin
			return;
		end
		if (wide_write_i && muldiv_i) begin
			m_hilo = wr_data64_i;
		end else if (float_write_i) begin
			if (!wr_addr_i[0]) begin
				m_fp[wr_addr_i[`RF_ADDR_W-1:1]] = wide_write_i ? wr_data64_i
					: rf_pkg::dword_t'(wr_data_i);
			end
		end else if (!wide_write_i) begin
			dest  = jal_i ? rf_pkg::reg_addr_t'(`RF_RA_IDX) : wr_addr_i;
			value = (load_byte_i && !jal_i) ? low_byte(wr_data_i) : wr_data_i;
			if (dest != '0) begin
				m_int[dest] = value;
			end
		end
	endfunction

	// expected outputs one cycle after the inputs are sampled
	always @(posedge Clk) begin
		rf_pkg::dword_t rs_pair;
		rf_pkg::dword_t rt_pair;
		rs_pair = m_fp[rs_addr_i[`RF_ADDR_W-1:1]];
		rt_pair = m_fp[rt_addr_i[`RF_ADDR_W-1:1]];
		if (rst_i) begin
			for (int i = 0; i < `RF_NREGS; i++) begin
				m_int[i] = '0;
			end
			for (int i = 0; i < `RF_NPAIRS; i++) begin
				m_fp[i] = '0;
			end
			m_hilo = '0;
			exp_rs_data <= '0;
			exp_rs_msw  <= '0;
			exp_rt_data <= '0;
			exp_rt_msw  <= '0;
		end else begin
			checked_cycles++;
			if (store_fp_i) begin
				exp_rs_data <= m_int[rs_addr_i];
				if (!rt_addr_i[0]) begin
					exp_rt_msw  <= msw(rt_pair);
					exp_rt_data <= lsw(rt_pair);
				end
			end else if (float_read_i) begin
				if (!rs_addr_i[0]) begin
					exp_rs_msw  <= msw(rs_pair);
					exp_rs_data <= lsw(rs_pair);
				end
				if (!rt_addr_i[0]) begin
					exp_rt_msw  <= msw(rt_pair);
					exp_rt_data <= lsw(rt_pair);
				end
			end else begin
				exp_rs_data <= m_int[rs_addr_i];
				exp_rt_data <= store_byte_i ? low_byte(m_int[rt_addr_i]) : m_int[rt_addr_i];
			end
			model_write(); // reads above still see the old state
		end
		exp_hi   <= msw(m_hilo);
		exp_lo   <= lsw(m_hilo);
		exp_flag <= m_int[`RF_FP_IDX][0];
	end

	task automatic report_mismatch(input string port, input rf_pkg::word_t exp_v,
		input rf_pkg::word_t act_v);
		mismatch_count++;
		$display("mismatch test %s port %s expected %h actual %h",
			test_name, port, exp_v, act_v);
	endtask

	a_rs_data: assert property (@(posedge Clk) disable iff (rst_i) rs_data_o == exp_rs_data)
		else report_mismatch("rs_data_o", $sampled(exp_rs_data), $sampled(rs_data_o));
	a_rs_msw: assert property (@(posedge Clk) disable iff (rst_i) rs_msw_o == exp_rs_msw)
		else report_mismatch("rs_msw_o", $sampled(exp_rs_msw), $sampled(rs_msw_o));
	a_rt_data: assert property (@(posedge Clk) disable iff (rst_i) rt_data_o == exp_rt_data)
		else report_mismatch("rt_data_o", $sampled(exp_rt_data), $sampled(rt_data_o));
	a_rt_msw: assert property (@(posedge Clk) disable iff (rst_i) rt_msw_o == exp_rt_msw)
		else report_mismatch("rt_msw_o", $sampled(exp_rt_msw), $sampled(rt_msw_o));
	a_hi: assert property (@(posedge Clk) disable iff (rst_i) hi_o == exp_hi)
		else report_mismatch("hi_o", $sampled(exp_hi), $sampled(hi_o));
	a_lo: assert property (@(posedge Clk) disable iff (rst_i) lo_o == exp_lo)
		else report_mismatch("lo_o", $sampled(exp_lo), $sampled(lo_o));
	a_flag: assert property (@(posedge Clk) disable iff (rst_i) fp_flag_o == exp_flag)
		else report_mismatch("fp_flag_o", rf_pkg::word_t'($sampled(exp_flag)),
			rf_pkg::word_t'($sampled(fp_flag_o)));

	task automatic next_cycle();
		@(posedge Clk);
		reg_write_i   <= 1'b0;
		load_byte_i   <= 1'b0;
		store_byte_i  <= 1'b0;
		jal_i         <= 1'b0;
		float_read_i  <= 1'b0;
		float_write_i <= 1'b0;
		wide_write_i  <= 1'b0;
		muldiv_i      <= 1'b0;
		store_fp_i    <= 1'b0;
	endtask

	task automatic set_read(input rf_pkg::reg_addr_t rs, input rf_pkg::reg_addr_t rt);
		rs_addr_i <= rs;
		rt_addr_i <= rt;
	endtask

	task automatic write_int(input rf_pkg::reg_addr_t addr, input rf_pkg::word_t data,
		input logic lb, input logic jal);
		next_cycle();
		wr_addr_i   <= addr;
		wr_data_i   <= data;
		load_byte_i <= lb;
		jal_i       <= jal;
		reg_write_i <= 1'b1;
	endtask

	task automatic write_float(input rf_pkg::reg_addr_t addr, input rf_pkg::word_t data,
		input rf_pkg::dword_t data64, input logic wide);
		next_cycle();
		wr_addr_i     <= addr;
		wr_data_i     <= data;
		wr_data64_i   <= data64;
		wide_write_i  <= wide;
		float_write_i <= 1'b1;
		reg_write_i   <= 1'b1;
	endtask

	task automatic write_wide(input rf_pkg::reg_addr_t addr, input rf_pkg::dword_t data64,
		input logic md);
		next_cycle();
		wr_addr_i    <= addr;
		wr_data64_i  <= data64;
		wide_write_i <= 1'b1;
		muldiv_i     <= md;
		reg_write_i  <= 1'b1;
	endtask

	task automatic read_regs(input rf_pkg::reg_addr_t rs, input rf_pkg::reg_addr_t rt,
		input logic fr, input logic sfp, input logic sb);
		next_cycle();
		set_read(rs, rt);
		float_read_i <= fr;
		store_fp_i   <= sfp;
		store_byte_i <= sb;
	endtask

	task automatic wait_flag(input logic want);
		int n;
		n = 0;
		do begin
			@(negedge Clk);
			n++;
		end while (fp_flag_o !== want && n < wait_limit);
		if (fp_flag_o !== want) begin
			timeout_count++;
			$display("timeout in %s: fp_flag_o did not become %0b within %0d cycles",
				test_name, want, wait_limit);
		end
	endtask

	task automatic wait_outputs_zero();
		int  n;
		logic clear;
		n = 0;
		do begin
			@(negedge Clk);
			n++;
			clear = (rs_data_o | rs_msw_o | rt_data_o | rt_msw_o | hi_o | lo_o) == '0
				&& fp_flag_o == 1'b0;
		end while (!clear && n < wait_limit);
		if (!clear) begin
			timeout_count++;
			$display("timeout in %s: outputs did not clear within %0d cycles of reset",
				test_name, wait_limit);
		end
	endtask

	initial begin
		rf_pkg::reg_addr_t a;
		rf_pkg::reg_addr_t b;
		rf_pkg::word_t     w;
		rst_i         = 1'b1;
		rs_addr_i     = '0;
		rt_addr_i     = '0;
		wr_addr_i     = '0;
		wr_data_i     = '0;
		wr_data64_i   = '0;
		reg_write_i   = 1'b0;
		load_byte_i   = 1'b0;
		store_byte_i  = 1'b0;
		jal_i         = 1'b0;
		float_read_i  = 1'b0;
		float_write_i = 1'b0;
		wide_write_i  = 1'b0;
		muldiv_i      = 1'b0;
		store_fp_i    = 1'b0;
		lfsr_q        = 16'd37;
		repeat (16) @(posedge Clk);
		rst_i <= 1'b0;

		test_name = "int_rw";
		for (int i = 0; i < 12; i++) begin
			a = rand_addr();
			write_int(a, rand_word(), 1'b0, 1'b0);
			set_read(a, rand_addr()); // read on the writing edge sees the old value
			read_regs(rand_addr(), a, 1'b0, 1'b0, 1'b0);
		end
		write_int('0, rand_word(), 1'b0, 1'b0);
		read_regs('0, '0, 1'b0, 1'b0, 1'b0);

		test_name = "byte_ops";
		for (int i = 0; i < 6; i++) begin
			a = rand_addr();
			b = rand_addr();
			write_int(a, rand_word(), 1'b1, 1'b0);
			read_regs(a, b, 1'b0, 1'b0, 1'b0);
			write_int(b, rand_word(), 1'b0, 1'b0);
			read_regs(b, b, 1'b0, 1'b0, 1'b1); // rt masked while rs reads whole
		end

		test_name = "jal_flag";
		write_int(rand_addr(), rand_word(), 1'b1, 1'b1); // byte strobe loses to jal
		read_regs(rf_pkg::reg_addr_t'(`RF_RA_IDX), rand_addr(), 1'b0, 1'b0, 1'b0);
		w = rand_word();
		write_int(rf_pkg::reg_addr_t'(`RF_FP_IDX), w & ~32'h1, 1'b0, 1'b0);
		wait_flag(1'b0);
		write_int(rf_pkg::reg_addr_t'(`RF_FP_IDX), w | 32'h1, 1'b0, 1'b0);
		wait_flag(1'b1);
		write_int(rf_pkg::reg_addr_t'(`RF_FP_IDX), w & ~32'h1, 1'b0, 1'b0);
		wait_flag(1'b0);

		test_name = "float";
		for (int i = 0; i < 6; i++) begin
			a = rand_even_addr();
			write_float(a, rand_word(), rand_dword(), 1'b1);
			read_regs(a, a, 1'b1, 1'b0, 1'b0);
			b = rand_even_addr();
			write_float(b, rand_word(), rand_dword(), 1'b0); // msw cleared
			read_regs(a, b, 1'b1, 1'b0, 1'b0);
		end
		write_float(a | 5'd1, rand_word(), rand_dword(), 1'b1); // odd address writes nothing
		read_regs(a, a, 1'b1, 1'b0, 1'b0);
		read_regs(a ^ 5'd3, b, 1'b1, 1'b0, 1'b0); // rs holds
		read_regs(b | 5'd1, a | 5'd1, 1'b1, 1'b0, 1'b0);

		test_name = "hilo";
		write_wide(rand_addr(), rand_dword(), 1'b1);
		write_wide(a, rand_dword(), 1'b0); // lands nowhere
		read_regs(a, a, 1'b1, 1'b0, 1'b0);
		read_regs(a, a, 1'b0, 1'b0, 1'b0);
		write_wide(rand_addr(), rand_dword(), 1'b1);

		test_name = "random";
		for (int i = 0; i < 64; i++) begin
			next_cycle();
			wr_addr_i     <= rand_addr();
			wr_data_i     <= rand_word();
			wr_data64_i   <= rand_dword();
			rs_addr_i     <= rand_addr();
			rt_addr_i     <= rand_addr();
			reg_write_i   <= rand_bit();
			load_byte_i   <= rand_bit();
			store_byte_i  <= rand_bit();
			jal_i         <= rand_bit();
			float_read_i  <= rand_bit();
			float_write_i <= rand_bit();
			wide_write_i  <= rand_bit();
			muldiv_i      <= rand_bit();
			store_fp_i    <= rand_bit();
		end

		test_name = "store_fp";
		b = rand_even_addr();
		write_float(b, rand_word(), rand_dword(), 1'b1);
		a = rand_addr();
		write_int(a, rand_word(), 1'b0, 1'b0);
		read_regs(a, b, 1'b0, 1'b1, 1'b0);
		read_regs(rand_addr(), b ^ 5'd3, 1'b0, 1'b1, 1'b0); // odd rt holds

		test_name = "reset";
		next_cycle();
		rst_i <= 1'b1;
		wait_outputs_zero();
		@(posedge Clk);
		rst_i <= 1'b0;
		read_regs(a, b, 1'b1, 1'b0, 1'b0);
		next_cycle();
		repeat (2) @(posedge Clk);
		@(negedge Clk);

		$display("checked %0d cycles, %0d mismatches, %0d timeouts",
			checked_cycles, mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/reg_file_top.sv
// register file top: integer, float and hi/lo banks with a registered read mux
`default_nettype none

`include "rf_macros.svh"

module reg_file_top (
	input wire logic              Clk,
	input wire logic              rst_i,
	input wire rf_pkg::reg_addr_t rs_addr_i,
	input wire rf_pkg::reg_addr_t rt_addr_i,
	input wire rf_pkg::reg_addr_t wr_addr_i,
	input wire rf_pkg::word_t     wr_data_i,
	input wire rf_pkg::dword_t    wr_data64_i,
	input wire logic              reg_write_i,
	input wire logic              load_byte_i,
	input wire logic              store_byte_i,
	input wire logic              jal_i,
	input wire logic              float_read_i,
	input wire logic              float_write_i,
	input wire logic              wide_write_i,
	input wire logic              muldiv_i,
	input wire logic              store_fp_i,
	output wire rf_pkg::word_t    rs_data_o,
	output wire rf_pkg::word_t    rs_msw_o,
	output wire rf_pkg::word_t    rt_data_o,
	output wire rf_pkg::word_t    rt_msw_o,
	output wire rf_pkg::word_t    hi_o,
	output wire rf_pkg::word_t    lo_o,
	output wire logic             fp_flag_o
);

	rf_wr_if wr_bus ();

	wire rf_pkg::word_t  int_rs_w;
	wire rf_pkg::word_t  int_rt_w;
	wire rf_pkg::dword_t fp_rs_w;
	wire rf_pkg::dword_t fp_rt_w;

	rf_write_decode u_decode (
		.wr_addr_i     (wr_addr_i),
		.wr_data_i     (wr_data_i),
		.wr_data64_i   (wr_data64_i),
		.reg_write_i   (reg_write_i),
		.load_byte_i   (load_byte_i),
		.jal_i         (jal_i),
		.float_write_i (float_write_i),
		.wide_write_i  (wide_write_i),
		.muldiv_i      (muldiv_i),
		.wr_o          (wr_bus.decoder)
	);

	int_reg_bank u_int_bank (
		.Clk       (Clk),
		.rst_i     (rst_i),
		.wr_i      (wr_bus.bank),
		.rs_addr_i (rs_addr_i),
		.rt_addr_i (rt_addr_i),
		.rs_word_o (int_rs_w),
		.rt_word_o (int_rt_w),
		.hi_o      (hi_o),
		.lo_o      (lo_o),
		.fp_flag_o (fp_flag_o)
	);

	// pair number is the register number without its low bit
	fp_reg_bank u_fp_bank (
		.Clk       (Clk),
		.rst_i     (rst_i),
		.wr_i      (wr_bus.bank),
		.rs_pair_i (rs_addr_i[`RF_ADDR_W-1:1]),
		.rt_pair_i (rt_addr_i[`RF_ADDR_W-1:1]),
		.rs_pair_o (fp_rs_w),
		.rt_pair_o (fp_rt_w)
	);

	rf_read_mux u_read_mux (
		.Clk          (Clk),
		.rst_i        (rst_i),
		.rs_addr_i    (rs_addr_i),
		.rt_addr_i    (rt_addr_i),
		.float_read_i (float_read_i),
		.store_fp_i   (store_fp_i),
		.store_byte_i (store_byte_i),
		.int_rs_i     (int_rs_w),
		.int_rt_i     (int_rt_w),
		.fp_rs_i      (fp_rs_w),
		.fp_rt_i      (fp_rt_w),
		.rs_data_o    (rs_data_o),
		.rs_msw_o     (rs_msw_o),
		.rt_data_o    (rt_data_o),
		.rt_msw_o     (rt_msw_o)
	);

endmodule

`default_nettype wire

//--- design/rf_read_mux.sv
// read mux: picks integer or float data per read mode and registers the outputs
`default_nettype none

`include "rf_macros.svh"

module rf_read_mux (
	input wire logic              Clk,
	input wire logic              rst_i,
	input wire rf_pkg::reg_addr_t rs_addr_i,
	input wire rf_pkg::reg_addr_t rt_addr_i,
	input wire logic              float_read_i,
	input wire logic              store_fp_i,
	input wire logic              store_byte_i,
	input wire rf_pkg::word_t     int_rs_i,
	input wire rf_pkg::word_t     int_rt_i,
	input wire rf_pkg::dword_t    fp_rs_i,
	input wire rf_pkg::dword_t    fp_rt_i,
	output rf_pkg::word_t         rs_data_o,
	output rf_pkg::word_t         rs_msw_o,
	output rf_pkg::word_t         rt_data_o,
	output rf_pkg::word_t         rt_msw_o
);

	rf_pkg::word_t rt_byte; // sb source, low byte only
	logic          rs_even;
	logic          rt_even;

	assign rt_byte = rf_pkg::word_t'(int_rt_i[`RF_BYTE_W-1:0]);
	assign rs_even = !rs_addr_i[0];
	assign rt_even = !rt_addr_i[0];

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			rs_data_o <= '0;
			rs_msw_o  <= '0;
			rt_data_o <= '0;
			rt_msw_o  <= '0;
		end else if (store_fp_i) begin
			// base address from the integer bank, value from the float bank
			rs_data_o <= int_rs_i;
			if (rt_even) begin
				rt_msw_o  <= fp_rt_i[2*`RF_WORD_W-1:`RF_WORD_W];
				rt_data_o <= fp_rt_i[`RF_WORD_W-1:0];
			end
		end else if (float_read_i) begin
			if (rs_even) begin
				rs_msw_o  <= fp_rs_i[2*`RF_WORD_W-1:`RF_WORD_W];
				rs_data_o <= fp_rs_i[`RF_WORD_W-1:0];
			end
			if (rt_even) begin
				rt_msw_o  <= fp_rt_i[2*`RF_WORD_W-1:`RF_WORD_W];
				rt_data_o <= fp_rt_i[`RF_WORD_W-1:0];
			end
		end else begin
			rs_data_o <= int_rs_i;
			rt_data_o <= store_byte_i ? rt_byte : int_rt_i;
			// msw outputs keep the last float value
		end
	end

	a_msw_hold: assert property (
		@(posedge Clk) disable iff (rst_i)
		(!store_fp_i && !float_read_i) |=> ($stable(rs_msw_o) && $stable(rt_msw_o))
	);

endmodule

`default_nettype wire

//--- design/fp_reg_bank.sv
// float bank: sixteen 64-bit register pairs with pair write and two pair reads
`default_nettype none

`include "rf_macros.svh"

module fp_reg_bank (
	input wire logic              Clk,
	input wire logic              rst_i,
	rf_wr_if.bank                 wr_i,
	input wire rf_pkg::pair_idx_t rs_pair_i,
	input wire rf_pkg::pair_idx_t rt_pair_i,
	output rf_pkg::dword_t        rs_pair_o,
	output rf_pkg::dword_t        rt_pair_o
);

	// each entry holds {even reg, odd reg}, msw first as on big endian
	rf_pkg::dword_t pairs_q [`RF_NPAIRS];

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			for (int i = 0; i < `RF_NPAIRS; i++) begin
				pairs_q[i] <= '0;
			end
		end else if (wr_i.fp_we) begin
			pairs_q[wr_i.fp_pair] <= wr_i.fp_data; // both words at once
		end
	end

	assign rs_pair_o = pairs_q[rs_pair_i];
	assign rt_pair_o = pairs_q[rt_pair_i];

	a_pair_known: assert property (
		@(posedge Clk) disable iff (rst_i)
		wr_i.fp_we |-> !$isunknown(wr_i.fp_pair)
	);

endmodule

`default_nettype wire

//--- design/int_reg_bank.sv
// integer bank: 32 general registers plus hi/lo, two combinational read ports
`default_nettype none

`include "rf_macros.svh"

module int_reg_bank (
	input wire logic              Clk,
	input wire logic              rst_i,
	rf_wr_if.bank                 wr_i,
	input wire rf_pkg::reg_addr_t rs_addr_i,
	input wire rf_pkg::reg_addr_t rt_addr_i,
	output rf_pkg::word_t         rs_word_o,
	output rf_pkg::word_t         rt_word_o,
	output rf_pkg::word_t         hi_o,
	output rf_pkg::word_t         lo_o,
	output logic                  fp_flag_o
);

	rf_pkg::word_t  regs_q [`RF_NREGS]; // r0 is never written, so it reads zero
	rf_pkg::dword_t hilo_q;

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			for (int i = 0; i < `RF_NREGS; i++) begin
				regs_q[i] <= '0;
			end
			hilo_q <= '0;
		end else begin
			if (wr_i.int_we) begin
				regs_q[wr_i.int_addr] <= wr_i.int_data;
			end
			if (wr_i.hilo_we) begin
				hilo_q <= wr_i.hilo_data;
			end
		end
	end

	// read ports, no bypass of a write on the same edge
	assign rs_word_o = regs_q[rs_addr_i];
	assign rt_word_o = regs_q[rt_addr_i];

	assign hi_o      = hilo_q[2*`RF_WORD_W-1:`RF_WORD_W];
	assign lo_o      = hilo_q[`RF_WORD_W-1:0];
	assign fp_flag_o = regs_q[`RF_FP_IDX][0]; // flag lives in bit 0 of $fp

	// decoder must keep $zero out of the write path
	a_no_zero_write: assert property (
		@(posedge Clk) disable iff (rst_i)
		wr_i.int_we |-> (wr_i.int_addr != '0)
	);

	// only one of the three targets written per cycle
	a_one_target: assert property (
		@(posedge Clk) disable iff (rst_i)
		$onehot0({wr_i.int_we, wr_i.fp_we, wr_i.hilo_we})
	);

endmodule

`default_nettype wire

//--- design/rf_write_decode.sv
// write decoder: turns the write strobes into at most one bank write per cycle
`default_nettype none

`include "rf_macros.svh"

module rf_write_decode (
	input wire rf_pkg::reg_addr_t wr_addr_i,
	input wire rf_pkg::word_t     wr_data_i,
	input wire rf_pkg::dword_t    wr_data64_i,
	input wire logic              reg_write_i,
	input wire logic              load_byte_i,
	input wire logic              jal_i,
	input wire logic              float_write_i,
	input wire logic              wide_write_i,
	input wire logic              muldiv_i,
	rf_wr_if.decoder              wr_o
);

	rf_pkg::word_t     byte_ext; // low byte, zero extended
	rf_pkg::reg_addr_t int_target; // jal overrides the address

	assign byte_ext   = rf_pkg::word_t'(wr_data_i[`RF_BYTE_W-1:0]);
	assign int_target = jal_i ? rf_pkg::reg_addr_t'(`RF_RA_IDX) : wr_addr_i;

	// payloads are steered regardless, only the enables carry the decision
	assign wr_o.int_addr  = int_target;
	assign wr_o.int_data  = (!jal_i && load_byte_i) ? byte_ext : wr_data_i;
	assign wr_o.fp_pair   = wr_addr_i[`RF_ADDR_W-1:1];
	assign wr_o.fp_data   = wide_write_i ? wr_data64_i : rf_pkg::dword_t'(wr_data_i);
	assign wr_o.hilo_data = wr_data64_i;

	always_comb begin
		wr_o.int_we  = 1'b0;
		wr_o.fp_we   = 1'b0;
		wr_o.hilo_we = 1'b0;
		if (reg_write_i) begin
			if (wide_write_i && muldiv_i) begin
				wr_o.hilo_we = 1'b1; // mult/div result
			end else if (float_write_i) begin
				wr_o.fp_we = !wr_addr_i[0]; // odd pair address is dropped
			end else if (!wide_write_i) begin
				wr_o.int_we = (int_target != '0); // $zero stays zero
			end
			// wide write without muldiv or float lands nowhere
		end
	end

endmodule

`default_nettype wire

//--- design/rf_wr_if.sv
// write bus from the write decoder to the integer bank, float bank and hi/lo
`default_nettype none

interface rf_wr_if;

	// integer bank write
	logic              int_we;
	rf_pkg::reg_addr_t int_addr;
	rf_pkg::word_t     int_data;

	// float pair write
	logic              fp_we;
	rf_pkg::pair_idx_t fp_pair;
	rf_pkg::dword_t    fp_data; // msw goes to the even register

	// multiply/divide result
	logic              hilo_we;
	rf_pkg::dword_t    hilo_data; // hi in the upper word

	modport decoder (
		output int_we, int_addr, int_data,
		output fp_we, fp_pair, fp_data,
		output hilo_we, hilo_data
	);

	modport bank (
		input int_we, int_addr, int_data,
		input fp_we, fp_pair, fp_data,
		input hilo_we, hilo_data
	);

endinterface

`default_nettype wire

//--- design/rf_pkg.sv
// register file package: vector types shared by the banks, decoder and read mux
`default_nettype none

`include "rf_macros.svh"

package rf_pkg;

	// one integer or float register
	typedef logic [`RF_WORD_W-1:0] word_t;

	// float pair or hi/lo, msw in the upper half
	typedef logic [2*`RF_WORD_W-1:0] dword_t;

	// register number as seen on the address ports
	typedef logic [`RF_ADDR_W-1:0] reg_addr_t;

	// float pair number, register number without bit 0
	typedef logic [$clog2(`RF_NPAIRS)-1:0] pair_idx_t;

endpackage

`default_nettype wire

//--- include/rf_macros.svh
// register file macros: widths, register counts and fixed register numbers
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// data and address widths
`define RF_WORD_W 32
`define RF_ADDR_W 5
`define RF_BYTE_W 8

// bank sizes
`define RF_NREGS 32
`define RF_NPAIRS 16 // float pairs, even register numbers only

// registers with a fixed role
`define RF_RA_IDX 31 // return address, target of jal
`define RF_FP_IDX 30 // frame pointer, bit 0 is the fp flag

`endif
